// File: rtl/nic_pkg.sv
`default_nettype none

package nic_pkg;

  // ============================================================
  // Ring geometry
  // ============================================================

  // Nodes sit at ids 1 to NUM_NODES, the host bridge owns id 0
  localparam int         NUM_NODES     = 8;
  localparam logic [3:0] HOST_ID       = 4'd0;
  localparam int         REGS_PER_NODE = 4;

  // Laps a packet may complete before the ager takes it off the ring
  localparam int         AGE_LIMIT     = 3;

  // One registered stage per node plus the ager, so a full lap is
  // NUM_NODES + 1 clocks from the bridge back to the bridge
  localparam int         RING_LATENCY  = NUM_NODES + 1;

  // ============================================================
  // Packet format
  // ============================================================

  typedef enum logic [1:0] {
    CMD_NOP = 2'd0,
    CMD_WR  = 2'd1,
    CMD_RD  = 2'd2,
    CMD_RSP = 2'd3
  } pkt_cmd_e;

  // One ring slot, moved a stage per clock
  typedef struct packed {
    logic        valid;
    logic [3:0]  did;
    logic [3:0]  sid;
    logic [1:0]  age;
    pkt_cmd_e    cmd;
    logic [1:0]  reg_sel;
    logic [15:0] data;
  } Packet;

  // ============================================================
  // Host register map
  // ============================================================

  localparam int AXI_ADDR_W = 4;
  localparam int AXI_DATA_W = 32;

  localparam logic [1:0] AXI_OKAY   = 2'b00;
  localparam logic [1:0] AXI_SLVERR = 2'b10;

  localparam logic [AXI_ADDR_W-1:0] ADDR_TX     = 4'h0;
  localparam logic [AXI_ADDR_W-1:0] ADDR_RX     = 4'h4;
  localparam logic [AXI_ADDR_W-1:0] ADDR_STATUS = 4'h8;

  // TX word layout, low bit of each field
  localparam int TX_CMD_LO  = 30;
  localparam int TX_DID_LO  = 24;
  localparam int TX_REG_LO  = 16;
  localparam int TX_DATA_LO = 0;

  // RX word layout
  localparam int RX_VALID_BIT = 31;
  localparam int RX_ERR_BIT   = 30;
  localparam int RX_ID_LO     = 24;
  localparam int RX_DATA_LO   = 0;

  // STATUS word layout
  localparam int ST_BUSY_BIT = 31;
  localparam int ST_DROPS_LO = 0;

endpackage

`default_nettype wire

// File: rtl/pnode.sv
`timescale 1ns/1ns
`default_nettype none

module pnode import nic_pkg::*; (
  input  wire logic [3:0] node_id_i,
  input  wire logic       rst_n_i,
  input  wire logic       clk_i,
  input  wire Packet      packet_i,
  output Packet           packet_o
);

  // Local register file, indexed by the packet's reg_sel field
  logic [15:0] regs_q [REGS_PER_NODE];
  Packet       packet_q;
  logic        serve;
  logic [15:0] rsp_data;

  // ============================================================
  // Request decode
  // ============================================================

  // Only requests addressed to this node are answered, a response or NOP
  // with a matching did simply passes on
  assign serve = packet_i.valid
              && (packet_i.did == node_id_i)
              && ((packet_i.cmd == CMD_WR) || (packet_i.cmd == CMD_RD));

  // A write echoes its own data, a read returns the stored value
  assign rsp_data = (packet_i.cmd == CMD_WR) ? packet_i.data : regs_q[packet_i.reg_sel];

  // ============================================================
  // Slot register and register file
  // ============================================================

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      packet_q <= '0;
      for (int i = 0; i < REGS_PER_NODE; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      if (serve) begin
        if (packet_i.cmd == CMD_WR) begin
          regs_q[packet_i.reg_sel] <= packet_i.data;
        end
        // The slot is turned around in place and sent back to its source
        packet_q.valid   <= 1'b1;
        packet_q.did     <= packet_i.sid;
        packet_q.sid     <= node_id_i;
        packet_q.age     <= '0;
        packet_q.cmd     <= CMD_RSP;
        packet_q.reg_sel <= packet_i.reg_sel;
        packet_q.data    <= rsp_data;
      end else begin
        packet_q <= packet_i;
      end
    end
  end

  assign packet_o = packet_q;

  // A fresh response carrying this node as source (age still zero, it has
  // not yet passed the ager) must come from a valid request sent here
  a_rsp_from_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (packet_o.valid && (packet_o.cmd == CMD_RSP) && (packet_o.sid == node_id_i)
      && (packet_o.age == 2'd0))
    |-> $past(packet_i.valid && (packet_i.did == node_id_i)));

endmodule

`default_nettype wire

// File: rtl/nic_ager.sv
`timescale 1ns/1ns
`default_nettype none

module nic_ager import nic_pkg::*; (
  input  wire logic  rst_n_i,
  input  wire logic  clk_i,
  input  wire Packet packet_i,
  output Packet      packet_o,
  output logic       drop_o,
  output logic [7:0] drop_count_o
);

  Packet      packet_q;
  logic       drop_q;
  logic [7:0] drop_count_q;
  logic       expire;

  // This pass would complete the last permitted lap, so the slot goes
  // no further (typically a request to an id nobody owns)
  assign expire = packet_i.valid && (packet_i.age == 2'(AGE_LIMIT - 1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      packet_q     <= '0;
      drop_q       <= 1'b0;
      drop_count_q <= '0;
    end else begin
      drop_q <= expire;
      if (expire) begin
        packet_q <= '0;
        // Counter sticks at its maximum rather than wrapping
        if (drop_count_q != '1) begin
          drop_count_q <= drop_count_q + 8'd1;
        end
      end else begin
        packet_q <= packet_i;
        if (packet_i.valid) begin
          packet_q.age <= packet_i.age + 2'd1;
        end
      end
    end
  end

  assign packet_o     = packet_q;
  assign drop_o       = drop_q;
  assign drop_count_o = drop_count_q;

  // Every drop pulse stems from an occupied slot one clock earlier, and that
  // slot is a request, since the bridge claims each response on its first lap
  a_drop_needs_slot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    drop_o |-> $past(packet_i.valid && (packet_i.cmd != CMD_RSP)));

endmodule

`default_nettype wire

// File: rtl/node_ring.sv
`timescale 1ns/1ns
`default_nettype none

module node_ring import nic_pkg::*; (
  input  wire logic  rst_n_i,
  input  wire logic  clk_i,
  input  wire Packet packet_i,
  output Packet      packet_o,
  output logic       drop_o,
  output logic [7:0] drop_count_o
);

  // Entry 0 is the ring input, entry k the output of node k
  Packet [NUM_NODES:0] packets;

  assign packets[0] = packet_i;

  // ============================================================
  // Node chain, ids 1 to NUM_NODES
  // ============================================================

  for (genvar g = 0; g < NUM_NODES; g++) begin : g_nodes
    pnode i_pnode (
      .node_id_i (4'(g + 1)),
      .rst_n_i   (rst_n_i),
      .clk_i     (clk_i),
      .packet_i  (packets[g]),
      .packet_o  (packets[g+1])
    );
  end

  // The ager closes the lap and hands the slot back to the bridge
  nic_ager i_nic_ager (
    .rst_n_i      (rst_n_i),
    .clk_i        (clk_i),
    .packet_i     (packets[NUM_NODES]),
    .packet_o     (packet_o),
    .drop_o       (drop_o),
    .drop_count_o (drop_count_o)
  );

endmodule

`default_nettype wire

// File: rtl/ring_host_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module ring_host_bridge import nic_pkg::*; (
  input  wire logic                  rst_n_i,
  input  wire logic                  clk_i,
  input  wire logic [AXI_ADDR_W-1:0] s_awaddr_i,
  input  wire logic                  s_awvalid_i,
  output logic                       s_awready_o,
  input  wire logic [AXI_DATA_W-1:0] s_wdata_i,
  input  wire logic                  s_wvalid_i,
  output logic                       s_wready_o,
  output logic [1:0]                 s_bresp_o,
  output logic                       s_bvalid_o,
  input  wire logic                  s_bready_i,
  input  wire logic [AXI_ADDR_W-1:0] s_araddr_i,
  input  wire logic                  s_arvalid_i,
  output logic                       s_arready_o,
  output logic [AXI_DATA_W-1:0]      s_rdata_o,
  output logic [1:0]                 s_rresp_o,
  output logic                       s_rvalid_o,
  input  wire logic                  s_rready_i,
  output Packet                      ring_o,
  input  wire Packet                 ring_i,
  input  wire logic                  drop_i,
  input  wire logic [7:0]            drop_count_i
);

  typedef enum logic [1:0] {IDLE, INJECT, WAIT_RSP, RESP} state_e;

  state_e                  state_q;
  Packet                   req_q;
  logic                    awready_q;
  logic                    bvalid_q;
  logic [1:0]              bresp_q;
  logic                    arready_q;
  logic                    rvalid_q;
  logic [1:0]              rresp_q;
  logic [AXI_DATA_W-1:0]   rdata_q;
  logic                    rx_valid_q;
  logic                    rx_err_q;
  logic [3:0]              rx_id_q;
  logic [15:0]             rx_data_q;
  logic                    wr_hs;
  logic                    ar_hs;
  logic                    busy;
  logic                    cmd_ok;
  logic                    tx_go;
  logic                    wr_err;
  logic                    rsp_hit;
  pkt_cmd_e                tx_cmd;
  logic [AXI_DATA_W-1:0]   rx_word;
  logic [AXI_DATA_W-1:0]   status_word;

  // ============================================================
  // Host side decode
  // ============================================================

  // AWREADY and WREADY are one register, so both channels complete together
  assign wr_hs  = awready_q && s_awvalid_i && s_wvalid_i;
  assign ar_hs  = arready_q && s_arvalid_i;
  assign busy   = (state_q != IDLE);
  assign tx_cmd = pkt_cmd_e'(s_wdata_i[TX_CMD_LO +: 2]);
  assign cmd_ok = (tx_cmd == CMD_WR) || (tx_cmd == CMD_RD);
  assign tx_go  = wr_hs && (s_awaddr_i == ADDR_TX) && !busy && cmd_ok;
  // Rejected writes still get a B response, they are just never injected
  assign wr_err = (s_awaddr_i != ADDR_TX) || busy || !cmd_ok;

  // Our response is back, only one request is ever outstanding
  assign rsp_hit = (state_q == WAIT_RSP) && ring_i.valid
                && (ring_i.cmd == CMD_RSP) && (ring_i.did == HOST_ID);

  always_comb begin
    rx_word                     = '0;
    rx_word[RX_VALID_BIT]       = rx_valid_q;
    rx_word[RX_ERR_BIT]         = rx_err_q;
    rx_word[RX_ID_LO +: 4]      = rx_id_q;
    rx_word[RX_DATA_LO +: 16]   = rx_data_q;
    status_word                 = '0;
    status_word[ST_BUSY_BIT]    = busy;
    status_word[ST_DROPS_LO +: 8] = drop_count_i;
  end

  // ============================================================
  // Ring side
  // ============================================================

  // Unclaimed slots pass straight through, so a lap stays RING_LATENCY long
  always_comb begin
    ring_o = ring_i;
    if (rsp_hit) begin
      ring_o = '0;
    end
    if (state_q == INJECT) begin
      ring_o = req_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_go) begin
      req_q.valid   <= 1'b1;
      req_q.did     <= s_wdata_i[TX_DID_LO +: 4];
      req_q.sid     <= HOST_ID;
      req_q.age     <= '0;
      req_q.cmd     <= tx_cmd;
      req_q.reg_sel <= s_wdata_i[TX_REG_LO +: 2];
      req_q.data    <= s_wdata_i[TX_DATA_LO +: 16];
    end
  end

  // Request FSM and the RX register it fills
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      rx_valid_q <= 1'b0;
      rx_err_q   <= 1'b0;
      rx_id_q    <= '0;
      rx_data_q  <= '0;
    end else begin
      if (ar_hs && (s_araddr_i == ADDR_RX)) begin
        rx_valid_q <= 1'b0;
      end
      case (state_q)
        IDLE: begin
          if (tx_go) begin
            state_q <= INJECT;
          end
        end
        INJECT: state_q <= WAIT_RSP;
        WAIT_RSP: begin
          if (rsp_hit) begin
            rx_err_q  <= 1'b0;
            rx_id_q   <= ring_i.sid;
            rx_data_q <= ring_i.data;
            state_q   <= RESP;
          end else if (drop_i) begin
            // Nobody answered, report the id we tried
            rx_err_q  <= 1'b1;
            rx_id_q   <= req_q.did;
            rx_data_q <= '0;
            state_q   <= RESP;
          end
        end
        RESP: begin
          // Setting valid wins over a read-clear in the same cycle
          rx_valid_q <= 1'b1;
          state_q    <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // ============================================================
  // AXI4-Lite write and read channels
  // ============================================================

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      awready_q <= 1'b0;
      bvalid_q  <= 1'b0;
      bresp_q   <= AXI_OKAY;
    end else begin
      if (wr_hs) begin
        awready_q <= 1'b0;
        bvalid_q  <= 1'b1;
        bresp_q   <= wr_err ? AXI_SLVERR : AXI_OKAY;
      end else if (s_awvalid_i && s_wvalid_i && !bvalid_q) begin
        awready_q <= 1'b1;
      end
      if (bvalid_q && s_bready_i) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      rresp_q   <= AXI_OKAY;
      rdata_q   <= '0;
    end else begin
      if (ar_hs) begin
        arready_q <= 1'b0;
        rvalid_q  <= 1'b1;
        case (s_araddr_i)
          ADDR_RX: begin
            rdata_q <= rx_word;
            rresp_q <= AXI_OKAY;
          end
          ADDR_STATUS: begin
            rdata_q <= status_word;
            rresp_q <= AXI_OKAY;
          end
          // TX is write only
          default: begin
            rdata_q <= '0;
            rresp_q <= AXI_SLVERR;
          end
        endcase
      end else if (s_arvalid_i && !rvalid_q) begin
        arready_q <= 1'b1;
      end
      if (rvalid_q && s_rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  assign s_awready_o = awready_q;
  assign s_wready_o  = awready_q;
  assign s_bvalid_o  = bvalid_q;
  assign s_bresp_o   = bresp_q;
  assign s_arready_o = arready_q;
  assign s_rvalid_o  = rvalid_q;
  assign s_rresp_o   = rresp_q;
  assign s_rdata_o   = rdata_q;

  // While waiting only aged traffic from the ager may leave, never a new request
  a_no_inject_waiting: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == WAIT_RSP) |-> !(ring_o.valid && (ring_o.age == 2'd0)));

  // Any node answers after exactly one lap
  a_fixed_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_hit |-> $past(state_q == INJECT, RING_LATENCY));

endmodule

`default_nettype wire

// File: rtl/ring_top.sv
`timescale 1ns/1ns
`default_nettype none

module ring_top import nic_pkg::*; (
  input  wire logic                  rst_n_i,
  input  wire logic                  clk_i,
  input  wire logic [AXI_ADDR_W-1:0] s_awaddr_i,
  input  wire logic                  s_awvalid_i,
  output logic                       s_awready_o,
  input  wire logic [AXI_DATA_W-1:0] s_wdata_i,
  input  wire logic                  s_wvalid_i,
  output logic                       s_wready_o,
  output logic [1:0]                 s_bresp_o,
  output logic                       s_bvalid_o,
  input  wire logic                  s_bready_i,
  input  wire logic [AXI_ADDR_W-1:0] s_araddr_i,
  input  wire logic                  s_arvalid_i,
  output logic                       s_arready_o,
  output logic [AXI_DATA_W-1:0]      s_rdata_o,
  output logic [1:0]                 s_rresp_o,
  output logic                       s_rvalid_o,
  input  wire logic                  s_rready_i
);

  // Slot leaving the bridge and slot coming back from the ager
  Packet      ring_fwd;
  Packet      ring_ret;
  logic       drop;
  logic [7:0] drop_count;

  ring_host_bridge i_ring_host_bridge (
    .rst_n_i      (rst_n_i),
    .clk_i        (clk_i),
    .s_awaddr_i   (s_awaddr_i),
    .s_awvalid_i  (s_awvalid_i),
    .s_awready_o  (s_awready_o),
    .s_wdata_i    (s_wdata_i),
    .s_wvalid_i   (s_wvalid_i),
    .s_wready_o   (s_wready_o),
    .s_bresp_o    (s_bresp_o),
    .s_bvalid_o   (s_bvalid_o),
    .s_bready_i   (s_bready_i),
    .s_araddr_i   (s_araddr_i),
    .s_arvalid_i  (s_arvalid_i),
    .s_arready_o  (s_arready_o),
    .s_rdata_o    (s_rdata_o),
    .s_rresp_o    (s_rresp_o),
    .s_rvalid_o   (s_rvalid_o),
    .s_rready_i   (s_rready_i),
    .ring_o       (ring_fwd),
    .ring_i       (ring_ret),
    .drop_i       (drop),
    .drop_count_i (drop_count)
  );

  node_ring i_node_ring (
    .rst_n_i      (rst_n_i),
    .clk_i        (clk_i),
    .packet_i     (ring_fwd),
    .packet_o     (ring_ret),
    .drop_o       (drop),
    .drop_count_o (drop_count)
  );

endmodule

`default_nettype wire

// File: testbench/tb_ring_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ring_top import nic_pkg::*; ();

  // Worst case is about 200 host transactions of 40 clocks each
  localparam int          MAX_CYCLES     = 200 * 40 + 1000;
  localparam int          NUM_RANDOM_OPS = 96;
  localparam logic [31:0] RESP_OKAY      = 32'h0;
  localparam logic [31:0] RESP_SLVERR    = 32'h2;

  logic        clk;
  logic        rst_n;
  logic [3:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [3:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  // Reference copy of every node register plus the expected drop count
  logic [15:0] model_regs [1:8][0:3];
  int          model_drops;
  int          cycle_count = 0;
  int          checks;
  int          test_errors;
  int          tests;
  int          total_checks;
  int          total_errors;

  ring_top i_ring_top (
    .rst_n_i     (rst_n),
    .clk_i       (clk),
    .s_awaddr_i  (awaddr),
    .s_awvalid_i (awvalid),
    .s_awready_o (awready),
    .s_wdata_i   (wdata),
    .s_wvalid_i  (wvalid),
    .s_wready_o  (wready),
    .s_bresp_o   (bresp),
    .s_bvalid_o  (bvalid),
    .s_bready_i  (bready),
    .s_araddr_i  (araddr),
    .s_arvalid_i (arvalid),
    .s_arready_o (arready),
    .s_rdata_o   (rdata),
    .s_rresp_o   (rresp),
    .s_rvalid_o  (rvalid),
    .s_rready_i  (rready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Cycle counter doubles as the watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout, run still going after %0d cycles", cycle_count);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ============================================================
  // Checking and bus helpers
  // ============================================================

  task automatic expect_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("test %-22s checks %0d errors %0d", name, checks, test_errors);
    tests++;
    total_checks += checks;
    total_errors += test_errors;
    checks = 0;
    test_errors = 0;
  endtask

  // A ready seen high at a falling edge means the handshake lands on the next rising edge
  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] resp, output int hs_cycle);
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!awready && !wready) @(negedge clk);
    // Address and data channels are accepted in the same clock
    expect_equal("s_awready_o", 32'h1, 32'(awready));
    expect_equal("s_wready_o", 32'h1, 32'(wready));
    @(negedge clk);
    hs_cycle = cycle_count;
    awvalid  = 1'b0;
    wvalid   = 1'b0;
    bready   = 1'b1;
    while (!bvalid) @(negedge clk);
    resp = bresp;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output int hs_cycle);
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) @(negedge clk);
    @(negedge clk);
    hs_cycle = cycle_count;
    arvalid  = 1'b0;
    rready   = 1'b1;
    while (!rvalid) @(negedge clk);
    data = rdata;
    expect_equal("s_rresp_o", RESP_OKAY, 32'(rresp));
    @(negedge clk);
    rready = 1'b0;
  endtask

  // TX layout: command 31:30, destination 27:24, register 17:16, data 15:0
  function automatic logic [31:0] tx_word(input logic [1:0] cmd, input logic [3:0] did,
                                          input logic [1:0] sel, input logic [15:0] data);
    return {cmd, 2'b00, did, 6'b000000, sel, data};
  endfunction

  task automatic wait_until_idle();
    logic [31:0] word;
    int          cyc;
    do begin
      axi_read(ADDR_STATUS, word, cyc);
    end while (word[31]);
  endtask

  task automatic send_request(input logic [1:0] cmd, input logic [3:0] did,
                              input logic [1:0] sel, input logic [15:0] data,
                              output int hs_cycle);
    logic [1:0] resp;
    axi_write(ADDR_TX, tx_word(cmd, did, sel, data), resp, hs_cycle);
    expect_equal("s_bresp_o", RESP_OKAY, 32'(resp));
  endtask

  task automatic check_rx(input logic [3:0] did, input logic [15:0] data);
    logic [31:0] word;
    int          cyc;
    axi_read(ADDR_RX, word, cyc);
    expect_equal("rx.valid", 32'h1, 32'(word[31]));
    expect_equal("rx.error", 32'h0, 32'(word[30]));
    expect_equal("rx.node_id", 32'(did), 32'(word[27:24]));
    expect_equal("rx.data", 32'(data), 32'(word[15:0]));
  endtask

  // Round trip of a read request, the node must answer with the model value
  task automatic check_node_reg(input logic [3:0] did, input logic [1:0] sel);
    int cyc;
    send_request(CMD_RD, did, sel, 16'(($urandom)), cyc);
    wait_until_idle();
    check_rx(did, model_regs[did][sel]);
  endtask

  task automatic random_write();
    logic [3:0]  did;
    logic [1:0]  sel;
    logic [15:0] data;
    int          cyc;
    did  = 4'(1 + $urandom % NUM_NODES);
    sel  = 2'($urandom % REGS_PER_NODE);
    data = 16'($urandom);
    send_request(CMD_WR, did, sel, data, cyc);
    model_regs[did][sel] = data;
    wait_until_idle();
    check_rx(did, data);
  endtask

  // ============================================================
  // Test sequence
  // ============================================================

  initial begin
    logic [31:0] word;
    logic [1:0]  resp;
    logic [3:0]  did;
    logic [1:0]  sel;
    logic [15:0] data;
    logic [15:0] data2;
    int          wr_cyc;
    int          rd_cyc;
    int          latency;

    void'($urandom(32'h20a2_d25b));
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    model_drops  = 0;
    checks       = 0;
    test_errors  = 0;
    tests        = 0;
    total_checks = 0;
    total_errors = 0;
    for (int n = 1; n <= 8; n++) begin
      for (int r = 0; r < 4; r++) begin
        model_regs[n][r] = '0;
      end
    end
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // Nothing outstanding, nothing dropped, nothing received
    axi_read(ADDR_STATUS, word, rd_cyc);
    expect_equal("status.busy", 32'h0, 32'(word[31]));
    expect_equal("status.drop_count", 32'h0, 32'(word[7:0]));
    axi_read(ADDR_RX, word, rd_cyc);
    expect_equal("rx.valid", 32'h0, 32'(word[31]));
    end_test("reset_state");

    for (int i = 0; i < NUM_RANDOM_OPS; i++) begin
      if ($urandom % 2 == 0) begin
        random_write();
      end else begin
        check_node_reg(4'(1 + $urandom % NUM_NODES), 2'($urandom % REGS_PER_NODE));
      end
    end
    end_test("random_traffic");

    // One lap is nine stages, RX valid follows a clock after that
    did  = 4'(1 + $urandom % NUM_NODES);
    sel  = 2'($urandom % REGS_PER_NODE);
    data = 16'($urandom);
    send_request(CMD_WR, did, sel, data, wr_cyc);
    model_regs[did][sel] = data;
    do begin
      axi_read(ADDR_RX, word, rd_cyc);
    end while (!word[31]);
    latency = rd_cyc - wr_cyc;
    checks++;
    assert (latency >= RING_LATENCY + 1) else begin
      $display("RX valid showed up %0d cycles after the TX write, too early", latency);
      test_errors++;
    end
    expect_equal("rx.node_id", 32'(did), 32'(word[27:24]));
    expect_equal("rx.data", 32'(data), 32'(word[15:0]));
    end_test("fixed_latency");

    // Ids above eight belong to no node, so the ager must retire the packet
    did  = 4'(9 + $urandom % 7);
    sel  = 2'($urandom % REGS_PER_NODE);
    data = 16'($urandom);
    send_request(CMD_WR, did, sel, data, wr_cyc);
    wait_until_idle();
    model_drops++;
    axi_read(ADDR_RX, word, rd_cyc);
    expect_equal("rx.valid", 32'h1, 32'(word[31]));
    expect_equal("rx.error", 32'h1, 32'(word[30]));
    axi_read(ADDR_STATUS, word, rd_cyc);
    expect_equal("status.drop_count", 32'(model_drops), 32'(word[7:0]));
    for (int n = 1; n <= 8; n++) begin
      for (int r = 0; r < 4; r++) begin
        check_node_reg(4'(n), 2'(r));
      end
    end
    end_test("undeliverable_dest");

    // Second TX lands while the first is still on the ring
    did   = 4'(1 + $urandom % NUM_NODES);
    sel   = 2'($urandom % REGS_PER_NODE);
    data  = 16'($urandom);
    data2 = ~data;
    send_request(CMD_WR, did, sel, data, wr_cyc);
    model_regs[did][sel] = data;
    axi_write(ADDR_TX, tx_word(CMD_WR, did, sel, data2), resp, wr_cyc);
    expect_equal("s_bresp_o", RESP_SLVERR, 32'(resp));
    wait_until_idle();
    check_rx(did, data);
    check_node_reg(did, sel);
    end_test("busy_rejection");

    // The last RX read above consumed the response
    axi_read(ADDR_RX, word, rd_cyc);
    expect_equal("rx.valid", 32'h0, 32'(word[31]));
    end_test("read_clears_rx");

    $display("%0d tests, %0d checks, %0d errors", tests, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ring_net.f
rtl/nic_pkg.sv
rtl/pnode.sv
rtl/nic_ager.sv
rtl/node_ring.sv
rtl/ring_host_bridge.sv
rtl/ring_top.sv
testbench/tb_ring_top.sv

// File: Makefile
TOP := tb_ring_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f ring_net.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
